/* hw/spi_link_pkg.sv */
// Constants and types shared by the SPI link. Configuration width is fixed at six bytes.
`default_nettype none

package spi_link_pkg;

    // Command byte that opens a configuration frame
    localparam logic [7:0] config_command = 8'hBF;
    // Command byte that requests a soft reset of the driver FPGA
    localparam logic [7:0] reset_command = 8'hA5;
    // Reply byte while a Hall sensor change waits to be reported
    localparam logic [7:0] rotation_byte = 8'h4C;
    // Reply byte with nothing to report, also the miso level between frames
    localparam logic [7:0] idle_byte = 8'hFF;

    // Data bytes that follow config_command in one frame
    localparam int config_bytes = 6;

    // One received byte as handed from the shifter to the decoder
    typedef struct packed {
        logic       valid;
        logic       first;
        logic [7:0] data;
    } rx_byte_s;

    // Driver setpoints as seen by the motor drivers, drv0 in the low bits
    typedef struct packed {
        logic [15:0] drv2;
        logic [15:0] drv1;
        logic [15:0] drv0;
    } driver_cfg_s;

    // The decoder fills the word byte by byte while the drivers read it by field
    typedef union packed {
        logic [config_bytes-1:0][7:0] octet;
        driver_cfg_s                  drv;
    } drive_config_u;

    // Value after power-on reset and after a soft reset
    localparam drive_config_u default_config = '0;

    // Decoder states, IDLE waits for a command and COLLECT takes data bytes
    typedef enum logic {
        DEC_IDLE,
        DEC_COLLECT
    } decoder_state_e;

endpackage

`default_nettype wire

/* hw/spi_byte_shifter.sv */
// SPI mode 0 slave on sck; a byte cut short by ss rising is dropped and never reported.
`default_nettype none

module spi_byte_shifter import spi_link_pkg::*; (
    input  logic     sck,
    input  logic     nrst,
    input  logic     ss,
    input  logic     mosi,
    output logic     miso,
    input  logic     rotation_pending,
    output logic     rotation_sent,
    output rx_byte_s rx_byte
);

    // Bit position inside the current byte slot
    logic [2:0] bit_cnt;
    // Receive and transmit shift registers, both MSB first
    logic [7:0] rx_sr;
    logic [7:0] tx_sr;
    // High until the first complete byte of a frame has been delivered
    logic       first_pend;
    // Registered form of the received byte
    logic       rx_valid;
    logic       rx_first;
    logic [7:0] rx_data;
    // Start of a byte slot inside a frame
    logic       slot_start;
    // Eighth bit of a byte is being sampled at this edge
    logic       byte_done;

    assign slot_start = !ss && (bit_cnt == 3'd0);
    assign byte_done  = !ss && (bit_cnt == 3'd7);

    // The rotation byte is handed out in the same cycle the slot is loaded
    assign rotation_sent = slot_start && rotation_pending;

    // Outside a frame the line idles high
    assign miso = ss ? 1'b1 : tx_sr[7];

    assign rx_byte = '{valid: rx_valid, first: rx_first, data: rx_data};

    // The counter wraps after eight bits and restarts on every ss fall
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            bit_cnt <= '0;
        end else if (ss) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    always_ff @(posedge sck) begin
        if (!ss) begin
            rx_sr <= {rx_sr[6:0], mosi};
        end
    end

    // Any time spent with ss high marks the next full byte as first of frame
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            first_pend <= 1'b1;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= byte_done;
            if (ss) begin
                first_pend <= 1'b1;
            end else if (byte_done) begin
                first_pend <= 1'b0;
            end
        end
    end

    // Byte content, taken with the last mosi bit folded in
    always_ff @(posedge sck) begin
        if (byte_done) begin
            rx_data  <= {rx_sr[6:0], mosi};
            rx_first <= first_pend;
        end
    end

    // Load the reply at each slot start, then shift ones in behind it
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            tx_sr <= idle_byte;
        end else if (slot_start) begin
            tx_sr <= rotation_pending ? rotation_byte : idle_byte;
        end else if (!ss) begin
            tx_sr <= {tx_sr[6:0], 1'b1};
        end
    end

    // A byte is only reported when ss stayed low for all eight samples
    assert property (@(posedge sck) disable iff (!nrst)
        ss |=> !rx_byte.valid [*8]);

    // A sent report was pending and the rotation byte is what went on the line
    assert property (@(posedge sck) disable iff (!nrst)
        rotation_sent |-> rotation_pending ##1 (tx_sr == rotation_byte));

endmodule

`default_nettype wire

/* hw/frame_decoder.sv */
// Command decoder; a configuration commits only when all six data bytes arrive in one frame.
`default_nettype none

module frame_decoder import spi_link_pkg::*; (
    input  logic          sck,
    input  logic          nrst,
    input  rx_byte_s      rx_byte,
    output drive_config_u drive_config,
    output logic          new_config,
    output logic          soft_reset
);

    decoder_state_e state;
    // Index of the next data byte within the configuration
    logic [2:0]     byte_cnt;
    // Configuration under assembly, not visible to the drivers
    drive_config_u  staging;
    // Staging contents with the current byte already placed
    drive_config_u  staging_next;
    // Current byte is the last data byte of a configuration frame
    logic           last_byte;
    // Current byte is a data byte of an open configuration frame
    logic           data_byte;

    assign data_byte = rx_byte.valid && !rx_byte.first && (state == DEC_COLLECT);
    assign last_byte = data_byte && (byte_cnt == 3'(config_bytes - 1));

    always_comb begin
        staging_next = staging;
        staging_next.octet[byte_cnt] = rx_byte.data;
    end

    // Data bytes land by index, byte 0 first
    always_ff @(posedge sck) begin
        if (data_byte) begin
            staging <= staging_next;
        end
    end

    // A first byte always restarts command interpretation
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            state    <= DEC_IDLE;
            byte_cnt <= '0;
        end else if (rx_byte.valid && rx_byte.first) begin
            byte_cnt <= '0;
            if (rx_byte.data == config_command) begin
                state <= DEC_COLLECT;
            end else begin
                state <= DEC_IDLE;
            end
        end else if (last_byte) begin
            state    <= DEC_IDLE;
            byte_cnt <= '0;
        end else if (data_byte) begin
            byte_cnt <= byte_cnt + 3'd1;
        end
    end

    // Commit and soft reset share the output register, so they cannot collide
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            drive_config <= default_config;
            new_config   <= 1'b0;
            soft_reset   <= 1'b0;
        end else begin
            new_config <= 1'b0;
            soft_reset <= 1'b0;
            if (rx_byte.valid && rx_byte.first && rx_byte.data == reset_command) begin
                drive_config <= default_config;
                soft_reset   <= 1'b1;
            end else if (last_byte) begin
                // All 48 bits reach the drivers at one edge
                drive_config <= staging_next;
                new_config   <= 1'b1;
            end
        end
    end

    assert property (@(posedge sck) disable iff (!nrst)
        !(new_config && soft_reset));

    // The counter stays inside the data field and is parked outside a frame
    assert property (@(posedge sck) disable iff (!nrst)
        (byte_cnt < config_bytes) && (state == DEC_IDLE -> byte_cnt == '0));

endmodule

`default_nettype wire

/* hw/rotation_monitor.sv */
// Hall change detector; hall lines are taken as low at reset release, else one report fires.
`default_nettype none

module rotation_monitor (
    input  logic       sck,
    input  logic       nrst,
    input  logic [2:0] hall,
    input  logic       rotation_sent,
    output logic       rotation_pending
);

    // Two-flop synchroniser for the asynchronous sensor lines
    logic [2:0] hall_meta;
    logic [2:0] hall_sync;
    // Synchronised value one cycle older
    logic [2:0] hall_prev;
    // Any sensor toggled since the last cycle
    logic       hall_change;

    assign hall_change = (hall_sync != hall_prev);

    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            hall_meta <= '0;
            hall_sync <= '0;
            hall_prev <= '0;
        end else begin
            hall_meta <= hall;
            hall_sync <= hall_meta;
            hall_prev <= hall_sync;
        end
    end

    // Sticky flag; a change seen in the cycle of a report keeps it set
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            rotation_pending <= 1'b0;
        end else if (hall_change) begin
            rotation_pending <= 1'b1;
        end else if (rotation_sent) begin
            rotation_pending <= 1'b0;
        end
    end

    // Only the shifter's report may consume a pending rotation
    assert property (@(posedge sck) disable iff (!nrst)
        $fell(rotation_pending) |-> $past(rotation_sent));

endmodule

`default_nettype wire

/* hw/spi_link_top.sv */
// SPI control link top, all logic on sck in mode 0 with ss active low.
`default_nettype none

module spi_link_top import spi_link_pkg::*; (
    input  logic          sck,
    input  logic          nrst,
    input  logic          ss,
    input  logic          mosi,
    input  logic [2:0]    hall,
    output logic          miso,
    output drive_config_u drive_config,
    output logic          new_config,
    output logic          soft_reset
);

    rx_byte_s rx_byte;
    logic     rotation_pending;
    logic     rotation_sent;

    // Bit level SPI and choice of reply byte
    spi_byte_shifter u_shifter (
        .sck              (sck),
        .nrst             (nrst),
        .ss               (ss),
        .mosi             (mosi),
        .miso             (miso),
        .rotation_pending (rotation_pending),
        .rotation_sent    (rotation_sent),
        .rx_byte          (rx_byte)
    );

    // Commands and configuration
    frame_decoder u_decoder (
        .sck          (sck),
        .nrst         (nrst),
        .rx_byte      (rx_byte),
        .drive_config (drive_config),
        .new_config   (new_config),
        .soft_reset   (soft_reset)
    );

    // Hall sensors feed the pending report back to the shifter
    rotation_monitor u_rotation (
        .sck              (sck),
        .nrst             (nrst),
        .hall             (hall),
        .rotation_sent    (rotation_sent),
        .rotation_pending (rotation_pending)
    );

endmodule

`default_nettype wire

/* tb/tb_spi_link.sv */
// Directed testbench for the SPI link; sck runs freely, frames hold at most eight bytes.
`default_nettype none

module tb_spi_link import spi_link_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Bytes sent in all frames of the run (2 + 14 + 23 + 4 + 8)
    localparam int frame_bytes_total = 51;

    logic          sck;
    logic          nrst;
    logic          ss;
    logic          mosi;
    logic [2:0]    hall;
    logic          miso;
    drive_config_u drive_config;
    logic          new_config;
    logic          soft_reset;

    // Frame buffers shared by the frame task and the tests
    logic [7:0]    tx_bytes [0:7];
    logic [7:0]    rx_bytes [0:7];
    // Last configuration the drivers should hold
    drive_config_u expected_cfg = default_config;
    logic [31:0]   lfsr_state = 32'h403d_c772;
    int            new_config_cnt = 0;
    int            soft_reset_cnt = 0;

    spi_link_top dut (
        .sck          (sck),
        .nrst         (nrst),
        .ss           (ss),
        .mosi         (mosi),
        .hall         (hall),
        .miso         (miso),
        .drive_config (drive_config),
        .new_config   (new_config),
        .soft_reset   (soft_reset)
    );

    initial begin
        sck = 1'b0;
        forever #10 sck = ~sck;
    end

    // Strobes last one full cycle, so each falling edge sees a pulse once
    always @(negedge sck) begin
        if (new_config) begin
            new_config_cnt++;
        end
        if (soft_reset) begin
            soft_reset_cnt++;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] b);
        int i;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    task automatic check_config(input drive_config_u exp);
        if (drive_config !== exp) begin
            fail_run($sformatf("** Error: drive_config expected %h got %h", exp, drive_config));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            fail_run($sformatf("** Error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_pulse(input string name, input int exp, input int act);
        if (act !== exp) begin
            fail_run($sformatf("** Error: %s pulse count expected %h got %h", name, exp, act));
        end
    endtask

    // Called just after a rising edge. Each miso sample is taken at the falling
    // edge of the cell in which tx[i] is driven, so it holds the previous reply bit
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        int i;
        for (i = 7; i >= 0; i--) begin
            mosi <= tx[i];
            @(negedge sck);
            rx[i] = miso;
            @(posedge sck);
        end
    endtask

    // Sends tx_bytes[0..n-1] in one frame and leaves the replies in rx_bytes
    task automatic spi_frame(input int n);
        logic [7:0] raw [0:7];
        logic       tail;
        int         k;
        if (n < 1 || n > 8) begin
            fail_run("Frame length outside the supported range of one to eight bytes");
        end
        @(posedge sck);
        ss <= 1'b0;
        for (k = 0; k < n; k++) begin
            spi_byte(tx_bytes[k], raw[k]);
        end
        // The last reply bit is still on miso for one more cell
        @(negedge sck);
        tail = miso;
        @(posedge sck);
        ss   <= 1'b1;
        mosi <= 1'b0;
        // Realign the samples by one bit to get whole reply bytes
        for (k = 0; k < n; k++) begin
            rx_bytes[k] = {raw[k][6:0], (k + 1 < n) ? raw[k + 1][7] : tail};
        end
        // Commit and soft reset land one cycle after the last byte
        repeat (2) @(negedge sck);
    endtask

    // Sends a full configuration frame with random data and checks the commit
    task automatic commit_random_config();
        logic [7:0]    d [0:5];
        drive_config_u exp;
        int            base_new;
        int            base_soft;
        int            k;
        tx_bytes[0] = config_command;
        for (k = 0; k < config_bytes; k++) begin
            random_byte(d[k]);
            tx_bytes[k + 1] = d[k];
        end
        base_new  = new_config_cnt;
        base_soft = soft_reset_cnt;
        spi_frame(config_bytes + 1);
        // Each setpoint is a byte pair with the later byte high
        exp.drv.drv0 = {d[1], d[0]};
        exp.drv.drv1 = {d[3], d[2]};
        exp.drv.drv2 = {d[5], d[4]};
        check_pulse("new_config", 1, new_config_cnt - base_new);
        check_pulse("soft_reset", 0, soft_reset_cnt - base_soft);
        check_config(exp);
        expected_cfg = exp;
    endtask

    task automatic reset_defaults();
        logic [7:0] line;
        int         k;
        check_config(default_config);
        for (k = 7; k >= 0; k--) begin
            @(negedge sck);
            line[k] = miso;
        end
        check_byte("miso with ss high", idle_byte, line);
        tx_bytes[0] = 8'h00;
        tx_bytes[1] = 8'h00;
        spi_frame(2);
        check_byte("miso reply 0", idle_byte, rx_bytes[0]);
        check_byte("miso reply 1", idle_byte, rx_bytes[1]);
        check_pulse("new_config", 0, new_config_cnt);
        check_pulse("soft_reset", 0, soft_reset_cnt);
        check_config(default_config);
    endtask

    task automatic config_commit();
        commit_random_config();
        commit_random_config();
    endtask

    task automatic ignored_frames();
        int base_new;
        int k;
        base_new = new_config_cnt;
        // Configuration cut after three data bytes
        tx_bytes[0] = config_command;
        for (k = 1; k < 4; k++) begin
            random_byte(tx_bytes[k]);
        end
        spi_frame(4);
        check_config(expected_cfg);
        // Unknown command with a full set of data bytes behind it
        tx_bytes[0] = 8'h3C;
        for (k = 1; k < 7; k++) begin
            random_byte(tx_bytes[k]);
        end
        spi_frame(7);
        check_config(expected_cfg);
        // Stray data with no command in front
        tx_bytes[0] = 8'h00;
        for (k = 1; k < 5; k++) begin
            random_byte(tx_bytes[k]);
        end
        spi_frame(5);
        check_config(expected_cfg);
        check_pulse("new_config", 0, new_config_cnt - base_new);
        commit_random_config();
    endtask

    task automatic rotation_report();
        int base_new;
        int base_soft;
        base_new  = new_config_cnt;
        base_soft = soft_reset_cnt;
        @(posedge sck);
        hall <= hall ^ 3'b010;
        // Synchroniser plus change detect need three edges
        repeat (4) @(posedge sck);
        tx_bytes[0] = 8'h00;
        tx_bytes[1] = 8'h00;
        spi_frame(2);
        check_byte("miso reply 0", rotation_byte, rx_bytes[0]);
        check_byte("miso reply 1", idle_byte, rx_bytes[1]);
        spi_frame(2);
        check_byte("miso reply 0", idle_byte, rx_bytes[0]);
        check_byte("miso reply 1", idle_byte, rx_bytes[1]);
        check_pulse("new_config", 0, new_config_cnt - base_new);
        check_pulse("soft_reset", 0, soft_reset_cnt - base_soft);
    endtask

    task automatic soft_reset_frame();
        int base_new;
        int base_soft;
        commit_random_config();
        base_new  = new_config_cnt;
        base_soft = soft_reset_cnt;
        tx_bytes[0] = reset_command;
        spi_frame(1);
        check_pulse("soft_reset", 1, soft_reset_cnt - base_soft);
        check_pulse("new_config", 0, new_config_cnt - base_new);
        check_config(default_config);
    endtask

    initial begin
        nrst = 1'b0;
        ss   = 1'b1;
        mosi = 1'b0;
        hall = 3'b000;
        repeat (2) @(posedge sck);
        nrst <= 1'b1;
        reset_defaults();
        config_commit();
        ignored_frames();
        rotation_report();
        soft_reset_frame();
        $display("*** PASSED ***");
        $finish;
    end

    // Every byte costs eight cycles, doubled for frame overhead
    initial begin
        repeat (frame_bytes_total * 8 * 2 + 200) @(posedge sck);
        fail_run("Run timed out before all tests finished");
    end

endmodule

`default_nettype wire

/* all.f */
hw/spi_link_pkg.sv
hw/spi_byte_shifter.sv
hw/frame_decoder.sv
hw/rotation_monitor.sv
hw/spi_link_top.sv
tb/tb_spi_link.sv

/* Bender.yml */
package:
  name: spi_link

sources:
  - files:
      - hw/spi_link_pkg.sv
      - hw/spi_byte_shifter.sv
      - hw/frame_decoder.sv
      - hw/rotation_monitor.sv
      - hw/spi_link_top.sv
  - target: test
    files:
      - tb/tb_spi_link.sv
